/* design/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve
    import mips_pkg::*;
(
    input  logic [XLEN-1:0] inst_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs_data_i,
    input  logic [XLEN-1:0] rt_data_i,
    dec_ctrl_if.sink        ctrl,
    output logic            jump_o,
    output logic [XLEN-1:0] jump_addr_o
);

    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] br_off;
    logic            rs_neg;
    logic            rs_zero;

    assign pc_plus4 = pc_i + XLEN'(4); // delay slot address
    assign br_off   = {{(XLEN-IMM_W-2){inst_i[IMM_W-1]}}, inst_i[IMM_W-1:0], 2'b00};
    assign rs_neg   = rs_data_i[XLEN-1];
    assign rs_zero  = (rs_data_i == '0);

    always_comb begin
        case (ctrl.op)
            ALU_BEQ:    jump_o = (rs_data_i == rt_data_i);
            ALU_BNE:    jump_o = (rs_data_i != rt_data_i);
            ALU_BLEZ:   jump_o = rs_neg || rs_zero;
            ALU_BGTZ:   jump_o = !rs_neg && !rs_zero; // strictly positive
            ALU_BLTZ:   jump_o = rs_neg;
            ALU_BGEZAL: jump_o = !rs_neg;
            ALU_J, ALU_JAL, ALU_JR, ALU_JALR: jump_o = 1'b1;
            default:    jump_o = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.op)
            ALU_BEQ, ALU_BNE, ALU_BLEZ, ALU_BGTZ, ALU_BLTZ, ALU_BGEZAL: begin
                jump_addr_o = pc_plus4 + br_off;
            end
            ALU_J, ALU_JAL: begin
                jump_addr_o = {pc_plus4[XLEN-1:JIDX_W+2], inst_i[JIDX_W-1:0], 2'b00};
            end
            ALU_JR, ALU_JALR: jump_addr_o = rs_data_i;
            default:          jump_addr_o = '0;
        endcase
    end

endmodule

/* design/dec_ctrl_if.sv */
`timescale 1ns/1ps

interface dec_ctrl_if
    import mips_pkg::*;
();

    alu_op_e             op;
    op1_sel_e            op1_sel;
    op2_sel_e            op2_sel;
    logic                mem_rd;
    logic                mem_wr;
    logic                reg_wr;
    logic [REG_AW-1:0]   dest_addr;

    modport source (
        output op, op1_sel, op2_sel, mem_rd, mem_wr, reg_wr, dest_addr
    );

    modport operand (
        input op1_sel, op2_sel
    );

    modport sink (
        input op, op1_sel, op2_sel, mem_rd, mem_wr, reg_wr, dest_addr
    );

endinterface

/* design/idu_top.sv */
`timescale 1ns/1ps

module idu_top
    import mips_pkg::*;
#(
    parameter int CREDITS = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic [XLEN-1:0]   inst_i,
    input  logic [XLEN-1:0]   rs_data_i,
    input  logic [XLEN-1:0]   rt_data_i,
    input  logic              credit_i,
    output logic [REG_AW-1:0] rs_addr_o,
    output logic [REG_AW-1:0] rt_addr_o,
    output logic              ready_o,
    output logic              valid_o,
    output alu_op_e           op_o,
    output logic [XLEN-1:0]   opa_o,
    output logic [XLEN-1:0]   opb_o,
    output logic              mem_rd_o,
    output logic              mem_wr_o,
    output logic              reg_wr_o,
    output logic [REG_AW-1:0] dest_addr_o,
    output logic [XLEN-1:0]   store_data_o,
    output logic              jump_o,
    output logic [XLEN-1:0]   jump_addr_o
);

    logic [XLEN-1:0] opa;
    logic [XLEN-1:0] opb;
    logic            jump;
    logic [XLEN-1:0] jump_addr;

    dec_ctrl_if ctrl_if ();

    // async register file read
    assign rs_addr_o = inst_i[RS_LSB +: REG_AW];
    assign rt_addr_o = inst_i[RT_LSB +: REG_AW];

    inst_decoder u_dec (
        .inst_i (inst_i),
        .ctrl   (ctrl_if.source)
    );

    operand_select u_opsel (
        .inst_i    (inst_i),
        .pc_i      (pc_i),
        .rs_data_i (rs_data_i),
        .rt_data_i (rt_data_i),
        .ctrl      (ctrl_if.operand),
        .opa_o     (opa),
        .opb_o     (opb)
    );

    branch_resolve u_br (
        .inst_i      (inst_i),
        .pc_i        (pc_i),
        .rs_data_i   (rs_data_i),
        .rt_data_i   (rt_data_i),
        .ctrl        (ctrl_if.sink),
        .jump_o      (jump),
        .jump_addr_o (jump_addr)
    );

    issue_credit_stage #(
        .CREDITS (CREDITS)
    ) u_issue (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .credit_i     (credit_i),
        .ready_o      (ready_o),
        .ctrl         (ctrl_if.sink),
        .opa_i        (opa),
        .opb_i        (opb),
        .store_data_i (rt_data_i), // sw data is rt
        .jump_i       (jump),
        .jump_addr_i  (jump_addr),
        .valid_o      (valid_o),
        .op_o         (op_o),
        .opa_o        (opa_o),
        .opb_o        (opb_o),
        .mem_rd_o     (mem_rd_o),
        .mem_wr_o     (mem_wr_o),
        .reg_wr_o     (reg_wr_o),
        .dest_addr_o  (dest_addr_o),
        .store_data_o (store_data_o),
        .jump_o       (jump_o),
        .jump_addr_o  (jump_addr_o)
    );

endmodule

/* design/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder
    import mips_pkg::*;
(
    input  logic [XLEN-1:0] inst_i,
    dec_ctrl_if.source      ctrl
);

    alu_op_e           op;
    op1_sel_e          op1_sel;
    op2_sel_e          op2_sel;
    logic              mem_rd;
    logic              mem_wr;
    logic              reg_wr;
    logic [REG_AW-1:0] dest;
    logic              r_type;
    logic [REG_AW-1:0] rt_addr;
    logic [REG_AW-1:0] rd_addr;

    assign r_type  = (inst_i[XLEN-1:OPC_LSB] == '0);
    assign rt_addr = inst_i[RT_LSB +: REG_AW];
    assign rd_addr = inst_i[RD_LSB +: REG_AW];

    always_comb begin
        casez (inst_i)
            32'b000000_?????_?????_?????_00000_10000?: op = ALU_ADD; // add, addu
            32'b000000_?????_?????_?????_00000_10001?: op = ALU_SUB; // sub, subu
            32'b000000_?????_?????_?????_00000_100100: op = ALU_AND;
            32'b000000_?????_?????_?????_00000_100101: op = ALU_OR;
            32'b000000_?????_?????_?????_00000_100110: op = ALU_XOR;
            32'b000000_?????_?????_?????_00000_101010: op = ALU_SLT;
            32'b000000_00000_?????_?????_?????_000000: op = ALU_SLL;
            32'b000000_00000_?????_?????_?????_000010: op = ALU_SRL;
            32'b000000_00000_?????_?????_?????_000011: op = ALU_SRA;
            32'b000000_?????_00000_00000_00000_001000: op = ALU_JR;
            32'b000000_?????_00000_?????_00000_001001: op = ALU_JALR;
            32'b00100?_?????_?????_?????_?????_??????: op = ALU_ADD; // addi, addiu
            32'b001010_?????_?????_?????_?????_??????: op = ALU_SLT;
            32'b001011_?????_?????_?????_?????_??????: op = ALU_SLTU;
            32'b001100_?????_?????_?????_?????_??????: op = ALU_AND;
            32'b001101_?????_?????_?????_?????_??????: op = ALU_OR;
            32'b001110_?????_?????_?????_?????_??????: op = ALU_XOR;
            32'b001111_00000_?????_?????_?????_??????: op = ALU_LUI;
            32'b100011_?????_?????_?????_?????_??????: op = ALU_LW;
            32'b101011_?????_?????_?????_?????_??????: op = ALU_SW;
            32'b000100_?????_?????_?????_?????_??????: op = ALU_BEQ;
            32'b000101_?????_?????_?????_?????_??????: op = ALU_BNE;
            32'b000110_?????_00000_?????_?????_??????: op = ALU_BLEZ;
            32'b000111_?????_00000_?????_?????_??????: op = ALU_BGTZ;
            32'b000001_?????_00000_?????_?????_??????: op = ALU_BLTZ;
            32'b000001_?????_10001_?????_?????_??????: op = ALU_BGEZAL;
            32'b000010_?????_?????_?????_?????_??????: op = ALU_J;
            32'b000011_?????_?????_?????_?????_??????: op = ALU_JAL;
            default:                                    op = ALU_UNKNOWN;
        endcase
    end

    always_comb begin
        op1_sel = OP1_NONE;
        op2_sel = OP2_NONE;
        mem_rd  = 1'b0;
        mem_wr  = 1'b0;
        reg_wr  = 1'b0;
        dest    = '0;
        case (op)
            ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU: begin
                op1_sel = OP1_RS;
                reg_wr  = 1'b1;
                if (r_type) begin
                    op2_sel = OP2_RT;
                    dest    = rd_addr;
                end else begin
                    // logical immediates are zero extended
                    op2_sel = (op == ALU_AND || op == ALU_OR || op == ALU_XOR) ?
                              OP2_IMM_Z : OP2_IMM_S;
                    dest    = rt_addr;
                end
            end
            ALU_SLL, ALU_SRL, ALU_SRA: begin
                op1_sel = OP1_SA;
                op2_sel = OP2_RT;
                reg_wr  = 1'b1;
                dest    = rd_addr;
            end
            ALU_LUI: begin
                op1_sel = OP1_LUI;
                reg_wr  = 1'b1;
                dest    = rt_addr;
            end
            ALU_LW, ALU_SW: begin
                op1_sel = OP1_RS;    // base
                op2_sel = OP2_IMM_S; // offset
                mem_rd  = (op == ALU_LW);
                mem_wr  = (op == ALU_SW);
                reg_wr  = (op == ALU_LW);
                dest    = (op == ALU_LW) ? rt_addr : '0;
            end
            ALU_JAL, ALU_BGEZAL, ALU_JALR: begin
                op1_sel = OP1_PC;   // link value is pc + 4
                op2_sel = OP2_FOUR;
                reg_wr  = 1'b1;
                dest    = (op == ALU_JALR) ? rd_addr : RA_REG;
            end
            default: ;
        endcase
    end

    assign ctrl.op        = op;
    assign ctrl.op1_sel   = op1_sel;
    assign ctrl.op2_sel   = op2_sel;
    assign ctrl.mem_rd    = mem_rd;
    assign ctrl.mem_wr    = mem_wr;
    assign ctrl.reg_wr    = reg_wr;
    assign ctrl.dest_addr = dest;

endmodule

/* design/issue_credit_stage.sv */
`timescale 1ns/1ps

module issue_credit_stage
    import mips_pkg::*;
#(
    parameter int CREDITS = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid_i,
    input  logic              credit_i,
    output logic              ready_o,
    dec_ctrl_if.sink          ctrl,
    input  logic [XLEN-1:0]   opa_i,
    input  logic [XLEN-1:0]   opb_i,
    input  logic [XLEN-1:0]   store_data_i,
    input  logic              jump_i,
    input  logic [XLEN-1:0]   jump_addr_i,
    output logic              valid_o,
    output alu_op_e           op_o,
    output logic [XLEN-1:0]   opa_o,
    output logic [XLEN-1:0]   opb_o,
    output logic              mem_rd_o,
    output logic              mem_wr_o,
    output logic              reg_wr_o,
    output logic [REG_AW-1:0] dest_addr_o,
    output logic [XLEN-1:0]   store_data_o,
    output logic              jump_o,
    output logic [XLEN-1:0]   jump_addr_o
);

    localparam int CW = $clog2(CREDITS + 1);

    logic [CW-1:0] credit_cnt;
    logic          accept;

    assign ready_o = (credit_cnt != '0);
    assign accept  = inst_valid_i && ready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CW'(CREDITS); // downstream buffer empty
        end else if (accept && !credit_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!accept && credit_i && credit_cnt != CW'(CREDITS)) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o  <= 1'b0;
            op_o     <= ALU_NOP;
            mem_rd_o <= 1'b0;
            mem_wr_o <= 1'b0;
            reg_wr_o <= 1'b0;
            jump_o   <= 1'b0;
        end else begin
            valid_o  <= accept;
            op_o     <= accept ? ctrl.op : ALU_NOP;
            mem_rd_o <= accept && ctrl.mem_rd; // no side effects on idle cycles
            mem_wr_o <= accept && ctrl.mem_wr;
            reg_wr_o <= accept && ctrl.reg_wr;
            jump_o   <= accept && jump_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            opa_o        <= opa_i;
            opb_o        <= opb_i;
            dest_addr_o  <= ctrl.dest_addr;
            store_data_o <= store_data_i;
            jump_addr_o  <= jump_addr_i;
        end
    end

endmodule

/* design/mips_pkg.sv */
package mips_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [REG_AW-1:0] RA_REG = 5'd31; // link register

    // instruction field positions
    localparam int OPC_LSB = 26;
    localparam int RS_LSB  = 21;
    localparam int RT_LSB  = 16;
    localparam int RD_LSB  = 11;
    localparam int SA_LSB  = 6;
    localparam int SA_W    = 5;
    localparam int IMM_W   = 16;
    localparam int JIDX_W  = 26; // j/jal index

    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI,
        ALU_LW,
        ALU_SW,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLEZ,
        ALU_BGTZ,
        ALU_BLTZ,
        ALU_BGEZAL,
        ALU_J,
        ALU_JAL,
        ALU_JR,
        ALU_JALR,
        ALU_UNKNOWN,
        ALU_NOP     // idle slot in the issue register
    } alu_op_e;

    typedef enum logic [2:0] {
        OP1_NONE,
        OP1_RS,
        OP1_SA,
        OP1_LUI,
        OP1_PC
    } op1_sel_e;

    typedef enum logic [2:0] {
        OP2_NONE,
        OP2_RT,
        OP2_IMM_S,
        OP2_IMM_Z,
        OP2_FOUR
    } op2_sel_e;

endpackage

/* design/operand_select.sv */
`timescale 1ns/1ps

module operand_select
    import mips_pkg::*;
(
    input  logic [XLEN-1:0] inst_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs_data_i,
    input  logic [XLEN-1:0] rt_data_i,
    dec_ctrl_if.operand     ctrl,
    output logic [XLEN-1:0] opa_o,
    output logic [XLEN-1:0] opb_o
);

    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_z;
    logic [XLEN-1:0] sa_z;
    logic [XLEN-1:0] imm_hi;

    assign imm_s  = {{(XLEN-IMM_W){inst_i[IMM_W-1]}}, inst_i[IMM_W-1:0]};
    assign imm_z  = {{(XLEN-IMM_W){1'b0}}, inst_i[IMM_W-1:0]};
    assign sa_z   = {{(XLEN-SA_W){1'b0}}, inst_i[SA_LSB +: SA_W]};
    assign imm_hi = {inst_i[IMM_W-1:0], {(XLEN-IMM_W){1'b0}}}; // lui form

    always_comb begin
        case (ctrl.op1_sel)
            OP1_RS:  opa_o = rs_data_i;
            OP1_SA:  opa_o = sa_z;
            OP1_LUI: opa_o = imm_hi;
            OP1_PC:  opa_o = pc_i;
            default: opa_o = '0;
        endcase
    end

    always_comb begin
        case (ctrl.op2_sel)
            OP2_RT:    opb_o = rt_data_i;
            OP2_IMM_S: opb_o = imm_s;
            OP2_IMM_Z: opb_o = imm_z;
            OP2_FOUR:  opb_o = XLEN'(4);
            default:   opb_o = '0;
        endcase
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_idu -f tb.f -o tb_idu_sim
sim_out=$(./obj_dir/tb_idu_sim) || true
echo "$sim_out"

if grep -q "Test completed successfully" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

/* tb.f */
+incdir+test
design/mips_pkg.sv
design/dec_ctrl_if.sv
design/inst_decoder.sv
design/operand_select.sv
design/branch_resolve.sv
design/issue_credit_stage.sv
design/idu_top.sv
test/tb_idu.sv

/* test/tb_idu_vectors.svh */
// inst, pc, rs, rt | op, opa, opb, mem_rd, mem_wr, reg_wr, dest, jump, jump_addr, rnd
// rnd rows take rs and rt from $random and expect opa = rs, opb = rt
localparam int NROWS = 39;

vec_t tbl [NROWS] = '{
    '{'h00221820, 'h400, 'h5, 'h7, ALU_ADD, 'h5, 'h7, 0, 0, 1, 3, 0, 0, 0},
    '{'h00221822, 'h400, -3, 'h10, ALU_SUB, -3, 'h10, 0, 0, 1, 3, 0, 0, 0},
    '{'h00221824, 'h400, 0, 0, ALU_AND, 0, 0, 0, 0, 1, 3, 0, 0, 1},
    '{'h00221825, 'h400, 0, 0, ALU_OR, 0, 0, 0, 0, 1, 3, 0, 0, 1},
    '{'h00221826, 'h400, 0, 0, ALU_XOR, 0, 0, 0, 0, 1, 3, 0, 0, 1},
    '{'h0022182a, 'h400, 0, 0, ALU_SLT, 0, 0, 0, 0, 1, 3, 0, 0, 1},
    '{'h2085fff0, 'h400, 'h100, 'h9, ALU_ADD, 'h100, -16, 0, 0, 1, 5, 0, 0, 0},
    '{'h28858000, 'h400, -1, 'h9, ALU_SLT, -1, 'hffff8000, 0, 0, 1, 5, 0, 0, 0},
    '{'h3085f00f, 'h400, 'hffff, 'h9, ALU_AND, 'hffff, 'hf00f, 0, 0, 1, 5, 0, 0, 0},
    '{'h34858001, 'h400, 'h1, 'h9, ALU_OR, 'h1, 'h8001, 0, 0, 1, 5, 0, 0, 0},
    '{'h3885ffff, 'h400, -2, 'h9, ALU_XOR, -2, 'hffff, 0, 0, 1, 5, 0, 0, 0},
    '{'h3c051234, 'h400, 0, 'h9, ALU_LUI, 'h12340000, 0, 0, 0, 1, 5, 0, 0, 0},
    '{'h000219c0, 'h400, 0, 'habcd0123, ALU_SLL, 7, 'habcd0123, 0, 0, 1, 3, 0, 0, 0},
    '{'h000219c2, 'h400, 0, -8, ALU_SRL, 7, -8, 0, 0, 1, 3, 0, 0, 0},
    '{'h000219c3, 'h400, 0, 'h80000000, ALU_SRA, 7, 'h80000000, 0, 0, 1, 3, 0, 0, 0},
    '{'h8c85fffc, 'h400, 'h1000, 'h9, ALU_LW, 'h1000, -4, 1, 0, 1, 5, 0, 0, 0},
    '{'hac850010, 'h400, 'h2000, 'hdeadbeef, ALU_SW, 'h2000, 'h10, 0, 1, 0, 0, 0, 0, 0},
    // branch targets from pc 'h400
    '{'h10220010, 'h400, -7, -7, ALU_BEQ, 0, 0, 0, 0, 0, 0, 1, 'h444, 0},
    '{'h10220010, 'h400, 1, 2, ALU_BEQ, 0, 0, 0, 0, 0, 0, 0, 'h444, 0},
    '{'h1422fff0, 'h400, 3, 4, ALU_BNE, 0, 0, 0, 0, 0, 0, 1, 'h3c4, 0},
    '{'h1422fff0, 'h400, 9, 9, ALU_BNE, 0, 0, 0, 0, 0, 0, 0, 'h3c4, 0},
    '{'h18200004, 'h400, -1, 0, ALU_BLEZ, 0, 0, 0, 0, 0, 0, 1, 'h414, 0},
    '{'h18200004, 'h400, 0, 0, ALU_BLEZ, 0, 0, 0, 0, 0, 0, 1, 'h414, 0},
    '{'h18200004, 'h400, 5, 0, ALU_BLEZ, 0, 0, 0, 0, 0, 0, 0, 'h414, 0},
    '{'h1c200004, 'h400, -1, 0, ALU_BGTZ, 0, 0, 0, 0, 0, 0, 0, 'h414, 0},
    '{'h1c200004, 'h400, 0, 0, ALU_BGTZ, 0, 0, 0, 0, 0, 0, 0, 'h414, 0},
    '{'h1c200004, 'h400, 5, 0, ALU_BGTZ, 0, 0, 0, 0, 0, 0, 1, 'h414, 0},
    '{'h04200004, 'h400, -1, 0, ALU_BLTZ, 0, 0, 0, 0, 0, 0, 1, 'h414, 0},
    '{'h04200004, 'h400, 0, 0, ALU_BLTZ, 0, 0, 0, 0, 0, 0, 0, 'h414, 0},
    '{'h04200004, 'h400, 5, 0, ALU_BLTZ, 0, 0, 0, 0, 0, 0, 0, 'h414, 0},
    '{'h04310004, 'h400, -1, 0, ALU_BGEZAL, 'h400, 4, 0, 0, 1, 31, 0, 'h414, 0},
    '{'h04310004, 'h400, 0, 0, ALU_BGEZAL, 'h400, 4, 0, 0, 1, 31, 1, 'h414, 0},
    '{'h04310004, 'h400, 5, 0, ALU_BGEZAL, 'h400, 4, 0, 0, 1, 31, 1, 'h414, 0},
    '{'h08123456, 'h40000100, 0, 0, ALU_J, 0, 0, 0, 0, 0, 0, 1, 'h4048d158, 0},
    '{'h0fffffff, 'h40000100, 0, 0, ALU_JAL, 'h40000100, 4, 0, 0, 1, 31, 1, 'h4ffffffc, 0},
    '{'h01000008, 'h400, 'h12345678, 0, ALU_JR, 0, 0, 0, 0, 0, 0, 1, 'h12345678, 0},
    '{'h01004809, 'h400, 'h80000000, 0, ALU_JALR, 'h400, 4, 0, 0, 1, 9, 1, 'h80000000, 0},
    '{'h00220018, 'h400, 'h11, 'h22, ALU_UNKNOWN, 0, 0, 0, 0, 0, 0, 0, 0, 0}, // mult
    '{'hfc000000, 'h400, 'h11, 'h22, ALU_UNKNOWN, 0, 0, 0, 0, 0, 0, 0, 0, 0}
};

/* test/tb_idu.sv */
`timescale 1ns/1ps

module tb_idu
    import mips_pkg::*;
();

    typedef struct packed {
        logic [XLEN-1:0]   inst;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   rs;
        logic [XLEN-1:0]   rt;
        alu_op_e           op;
        logic [XLEN-1:0]   opa;
        logic [XLEN-1:0]   opb;
        logic              mem_rd;
        logic              mem_wr;
        logic              reg_wr;
        logic [REG_AW-1:0] dest;
        logic              jump;
        logic [XLEN-1:0]   jump_addr;
        logic              rnd;
    } vec_t;

    logic              clk;
    logic              rst;
    logic              inst_valid_i;
    logic [XLEN-1:0]   pc_i;
    logic [XLEN-1:0]   inst_i;
    logic [XLEN-1:0]   rs_data_i;
    logic [XLEN-1:0]   rt_data_i;
    logic              credit_i;
    logic [REG_AW-1:0] rs_addr_o;
    logic [REG_AW-1:0] rt_addr_o;
    logic              ready_o;
    logic              valid_o;
    alu_op_e           op_o;
    logic [XLEN-1:0]   opa_o;
    logic [XLEN-1:0]   opb_o;
    logic              mem_rd_o;
    logic              mem_wr_o;
    logic              reg_wr_o;
    logic [REG_AW-1:0] dest_addr_o;
    logic [XLEN-1:0]   store_data_o;
    logic              jump_o;
    logic [XLEN-1:0]   jump_addr_o;
    integer            seed;
    logic [XLEN-1:0]   drv_rs; // register data of the row in flight
    logic [XLEN-1:0]   drv_rt;

    `include "tb_idu_vectors.svh"

    idu_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .rs_data_i    (rs_data_i),
        .rt_data_i    (rt_data_i),
        .credit_i     (credit_i),
        .rs_addr_o    (rs_addr_o),
        .rt_addr_o    (rt_addr_o),
        .ready_o      (ready_o),
        .valid_o      (valid_o),
        .op_o         (op_o),
        .opa_o        (opa_o),
        .opb_o        (opb_o),
        .mem_rd_o     (mem_rd_o),
        .mem_wr_o     (mem_wr_o),
        .reg_wr_o     (reg_wr_o),
        .dest_addr_o  (dest_addr_o),
        .store_data_o (store_data_o),
        .jump_o       (jump_o),
        .jump_addr_o  (jump_addr_o)
    );

    always #50 clk = ~clk;

    task automatic step_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR t=%0t %s got %h expected %h", $time, name, got, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic apply_row(input vec_t row);
        if (row.rnd) begin
            drv_rs = $random(seed);
            drv_rt = $random(seed);
        end else begin
            drv_rs = row.rs;
            drv_rt = row.rt;
        end
        inst_valid_i = 1'b1;
        credit_i     = 1'b1; // downstream frees one entry per cycle
        inst_i       = row.inst;
        pc_i         = row.pc;
        rs_data_i    = drv_rs;
        rt_data_i    = drv_rt;
    endtask

    task automatic check_row(input vec_t row);
        logic [XLEN-1:0] exp_opa;
        logic [XLEN-1:0] exp_opb;
        exp_opa = row.rnd ? drv_rs : row.opa; // rs and rt pass through on register ALU rows
        exp_opb = row.rnd ? drv_rt : row.opb;
        check_val("rs_addr_o", 32'(rs_addr_o), 32'(row.inst[25:21]));
        check_val("rt_addr_o", 32'(rt_addr_o), 32'(row.inst[20:16]));
        check_val("valid_o", 32'(valid_o), 1);
        check_val("ready_o", 32'(ready_o), 1);
        check_val("op_o", 32'(op_o), 32'(row.op));
        check_val("opa_o", opa_o, exp_opa);
        check_val("opb_o", opb_o, exp_opb);
        check_val("mem_rd_o", 32'(mem_rd_o), 32'(row.mem_rd));
        check_val("mem_wr_o", 32'(mem_wr_o), 32'(row.mem_wr));
        check_val("reg_wr_o", 32'(reg_wr_o), 32'(row.reg_wr));
        if (row.reg_wr) begin
            check_val("dest_addr_o", 32'(dest_addr_o), 32'(row.dest));
        end
        check_val("store_data_o", store_data_o, drv_rt);
        check_val("jump_o", 32'(jump_o), 32'(row.jump));
        check_val("jump_addr_o", jump_addr_o, row.jump_addr);
    endtask

    initial begin
        int i;
        seed         = 32'h5f0774fd;
        clk          = 1'b0;
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        pc_i         = '0;
        inst_i       = '0;
        rs_data_i    = '0;
        rt_data_i    = '0;
        credit_i     = 1'b0;
        drv_rs       = '0;
        drv_rt       = '0;
        repeat (2) @(posedge clk);
        #5;
        check_val("ready_o", 32'(ready_o), 1); // full count out of reset
        check_val("valid_o", 32'(valid_o), 0);
        check_val("jump_o", 32'(jump_o), 0);
        check_val("mem_rd_o", 32'(mem_rd_o), 0);
        check_val("mem_wr_o", 32'(mem_wr_o), 0);
        check_val("reg_wr_o", 32'(reg_wr_o), 0);
        rst = 1'b0;

        for (i = 0; i < NROWS; i++) begin
            apply_row(tbl[i]);
            step_cycle();
            check_row(tbl[i]);
        end

        // credits withheld from here on
        inst_valid_i = 1'b0;
        credit_i     = 1'b0;
        step_cycle();
        check_val("valid_o", 32'(valid_o), 0);
        check_val("ready_o", 32'(ready_o), 1);
        inst_i       = 32'h8c85fffc;
        inst_valid_i = 1'b1;
        step_cycle();
        check_val("valid_o", 32'(valid_o), 1);
        check_val("ready_o", 32'(ready_o), 1);
        step_cycle();
        check_val("valid_o", 32'(valid_o), 1);
        check_val("ready_o", 32'(ready_o), 0); // both entries in use
        repeat (3) begin
            step_cycle();
            check_val("ready_o", 32'(ready_o), 0);
            check_val("valid_o", 32'(valid_o), 0);
        end
        credit_i = 1'b1;
        step_cycle();
        credit_i = 1'b0;
        check_val("ready_o", 32'(ready_o), 1);
        check_val("valid_o", 32'(valid_o), 0);
        step_cycle();
        check_val("valid_o", 32'(valid_o), 1); // held instruction issues
        check_val("ready_o", 32'(ready_o), 0);
        inst_valid_i = 1'b0;

        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #((NROWS + 20) * 100);
        $display("Timeout: the run did not finish in the expected time");
        $display("Test failed");
        $fatal(1);
    end

endmodule
